/* dv/simd_mul_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// valid timing and output checks, bound into simd_mul_top
////////////////////////////////////////////////////////////////////////////
`include "simd_mul_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module simd_mul_assertions (
    input  logic                     clk_i,
    input  logic                     async_rst_ni,
    input  logic                     in_valid_i,
    input  logic                     result_valid_i,
    input  simd_mul_pkg::simd_word_u result_i
);

    // number of failed assertions
    int unsigned assert_errors = 0;

    // every accepted item returns after the fixed latency, and nothing else does
    valid_latency_a: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        result_valid_i == $past(in_valid_i, `SIMD_MUL_LATENCY)
    ) else begin
        $error("result_valid_o does not follow in_valid_i by the pipeline latency");
        assert_errors++;
    end

    valid_in_reset_a: assert property (
        @(posedge clk_i) !async_rst_ni |=> !result_valid_i
    ) else begin
        $error("result_valid_o went high while reset was asserted");
        assert_errors++;
    end

    result_known_a: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        result_valid_i |-> !$isunknown(result_i)
    ) else begin
        $error("result_o has unknown bits while result_valid_o is high");
        assert_errors++;
    end

endmodule

bind simd_mul_top simd_mul_assertions simd_mul_assertions_i (
    .clk_i          (clk_i),
    .async_rst_ni   (async_rst_ni),
    .in_valid_i     (in_valid_i),
    .result_valid_i (result_valid_o),
    .result_i       (result_o)
);

`default_nettype wire

/* dv/simd_mul_tb.sv */
////////////////////////////////////////////////////////////////////////////
// directed tests against an element-wise model, results sampled on negedge
// assumes the fixed latency of SIMD_MUL_LATENCY and no back-pressure
////////////////////////////////////////////////////////////////////////////
`include "simd_mul_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module simd_mul_tb;
    import simd_mul_pkg::*;

    localparam int unsigned OP_W           = `SIMD_MUL_OP_W;
    localparam int unsigned LATENCY        = `SIMD_MUL_LATENCY;
    localparam int unsigned CLK_PERIOD_NS  = 4;
    localparam int unsigned RST_CYCLES     = 16;
    localparam int unsigned SEED           = 50;
    localparam int unsigned IDLE_CYCLES    = 10;
    localparam int unsigned DRAIN_LIMIT    = LATENCY + 4;
    localparam int unsigned VMUL_PER_CASE  = 3;
    localparam int unsigned VMULH_RANDOM   = 2;
    localparam int unsigned VSMUL_RANDOM   = 3;
    localparam int unsigned VMACC_PER_CASE = 3;
    localparam int unsigned STREAM_ITEMS   = 20;
    // vmul, vmulh, vsmul, vmacc, then the mixed stream
    localparam int unsigned ITEM_COUNT = 3 * 4 * VMUL_PER_CASE + 3 * 2 * (VMULH_RANDOM + 2)
                                       + 3 * (VSMUL_RANDOM + 2) + 3 * 2 * VMACC_PER_CASE
                                       + STREAM_ITEMS;
    localparam int unsigned MARGIN_CYCLES  = RST_CYCLES + IDLE_CYCLES
                                           + 5 * (DRAIN_LIMIT + 2) + 100;
    localparam int unsigned TIMEOUT_CYCLES = ITEM_COUNT * LATENCY + MARGIN_CYCLES;

    logic       clk_i = 1'b0;
    logic       async_rst_ni;
    logic       in_valid_i;
    mul_op_e    op_i;
    sew_e       sew_i;
    logic       op1_signed_i;
    logic       op2_signed_i;
    logic       acc_sub_i;
    simd_word_u op1_i;
    simd_word_u op2_i;
    simd_word_u acc_i;
    logic       result_valid_o;
    simd_word_u result_o;

    simd_word_u         exp_q [$];
    logic [LATENCY-1:0] valid_hist;
    string              test_name = "reset";
    int unsigned        value_errors = 0;
    int unsigned        valid_errors = 0;
    int unsigned        other_errors = 0;

    simd_mul_top simd_mul_top_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .in_valid_i     (in_valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .op1_signed_i   (op1_signed_i),
        .op2_signed_i   (op2_signed_i),
        .acc_sub_i      (acc_sub_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .acc_i          (acc_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin : clock_gen
        forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("ERROR: timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic int unsigned elem_bits(sew_e sew);
        case (sew)
            SEW_8:   return 8;
            SEW_16:  return 16;
            default: return 32;
        endcase
    endfunction

    function automatic simd_word_u expected_word(mul_op_e op, sew_e sew, logic s1, logic s2,
                                                 logic sub, simd_word_u a, simd_word_u b,
                                                 simd_word_u acc);
        logic [OP_W-1:0] av;
        logic [OP_W-1:0] bv;
        logic [OP_W-1:0] cv;
        logic [OP_W-1:0] res;
        logic [OP_W-1:0] r_wide;
        logic [63:0]     mask;
        logic [63:0]     x;
        logic [63:0]     y;
        logic [63:0]     z;
        logic [63:0]     p;
        logic [63:0]     s;
        logic [63:0]     r;
        int unsigned     w;
        w    = elem_bits(sew);
        mask = (64'd1 << w) - 1;
        av   = a;
        bv   = b;
        cv   = acc;
        res  = '0;
        for (int e = 0; e < OP_W / w; e++) begin
            x = 64'(av >> (e * w)) & mask;
            y = 64'(bv >> (e * w)) & mask;
            z = 64'(cv >> (e * w)) & mask;
            // extended to 64 bits, so the low 2w bits of the product are exact
            if (s1 && x[w-1]) begin
                x = x | ~mask;
            end
            if (s2 && y[w-1]) begin
                y = y | ~mask;
            end
            p = x * y;
            case (op)
                MUL_VMULH: r = p >> w;
                MUL_VSMUL: begin
                    // half an lsb of the result, then bits 2w-2 down to w-1
                    s = p + (64'd1 << (w - 2));
                    if (s[2*w-1] != s[2*w-2]) begin
                        r = mask >> 1;
                    end else begin
                        r = s >> (w - 1);
                    end
                end
                MUL_VMACC: r = sub ? z - p : z + p;
                default:   r = p;
            endcase
            r_wide = OP_W'(r & mask);
            res    = res | (r_wide << (e * w));
        end
        return res;
    endfunction

    function automatic simd_word_u rand_word();
        simd_word_u word;
        for (int i = 0; i < OP_W / 32; i++) begin
            word.w[i] = $urandom();
        end
        return word;
    endfunction

    // same value in every element
    function automatic simd_word_u fill_elem(sew_e sew, logic [31:0] val);
        logic [OP_W-1:0] word;
        int unsigned     w;
        w    = elem_bits(sew);
        word = '0;
        for (int e = 0; e < OP_W / w; e++) begin
            word = word | (OP_W'(64'(val) & ((64'd1 << w) - 1)) << (e * w));
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare, drive and collect

    task automatic check_word(input string name, input simd_word_u got, input simd_word_u exp);
        if (got !== exp) begin
            $display("FAIL %s (%s): got 0x%h, expected 0x%h", name, test_name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s (%s): got 0x%h, expected 0x%h", name, test_name, got, exp);
            valid_errors++;
        end
    endtask

    task automatic issue_item(input mul_op_e op, input sew_e sew, input logic s1,
                              input logic s2, input logic sub, input simd_word_u a,
                              input simd_word_u b, input simd_word_u acc);
        @(posedge clk_i);
        in_valid_i   <= 1'b1;
        op_i         <= op;
        sew_i        <= sew;
        op1_signed_i <= s1;
        op2_signed_i <= s2;
        acc_sub_i    <= sub;
        op1_i        <= a;
        op2_i        <= b;
        acc_i        <= acc;
        exp_q.push_back(expected_word(op, sew, s1, s2, sub, a, b, acc));
    endtask

    // stop issuing and wait until every outstanding item has come back
    task automatic wait_drain();
        int unsigned waited;
        @(posedge clk_i);
        in_valid_i <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d items of %s never came back", exp_q.size(), test_name);
            other_errors++;
            exp_q.delete();
        end
    endtask

    initial begin : monitor
        simd_word_u exp_word;
        valid_hist = '0;
        forever begin
            @(negedge clk_i);
            check_valid("result_valid_o", result_valid_o, valid_hist[LATENCY-1]);
            if (result_valid_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: a result came back with no item outstanding");
                    other_errors++;
                end else begin
                    exp_word = exp_q.pop_front();
                    check_word("result_o", result_o, exp_word);
                end
            end
            valid_hist = {valid_hist[LATENCY-2:0], in_valid_i};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_vmul_after_reset();
        sew_e sew;
        test_name = "vmul";
        // nothing issued yet
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            check_valid("result_valid_o", result_valid_o, 1'b0);
        end
        for (int wi = 0; wi < 3; wi++) begin
            sew = sew_e'(wi);
            for (int sg = 0; sg < 4; sg++) begin
                repeat (VMUL_PER_CASE) begin
                    issue_item(MUL_VMUL, sew, sg[1], sg[0], 1'b0,
                               rand_word(), rand_word(), rand_word());
                end
            end
        end
        wait_drain();
    endtask

    task automatic test_vmulh();
        sew_e       sew;
        simd_word_u min_w;
        simd_word_u ones_w;
        logic       sg;
        test_name = "vmulh";
        ones_w    = '1;
        for (int wi = 0; wi < 3; wi++) begin
            sew   = sew_e'(wi);
            min_w = fill_elem(sew, 32'd1 << (elem_bits(sew) - 1));
            for (int s = 0; s < 2; s++) begin
                sg = s[0];
                repeat (VMULH_RANDOM) begin
                    issue_item(MUL_VMULH, sew, sg, sg, 1'b0,
                               rand_word(), rand_word(), rand_word());
                end
                issue_item(MUL_VMULH, sew, sg, sg, 1'b0, min_w, min_w, rand_word());
                issue_item(MUL_VMULH, sew, sg, sg, 1'b0, ones_w, ones_w, rand_word());
            end
        end
        wait_drain();
    endtask

    task automatic test_vsmul();
        sew_e       sew;
        simd_word_u min_w;
        simd_word_u ones_w;
        test_name = "vsmul";
        ones_w    = '1;
        for (int wi = 0; wi < 3; wi++) begin
            sew   = sew_e'(wi);
            min_w = fill_elem(sew, 32'd1 << (elem_bits(sew) - 1));
            // acc_sub_i and acc_i must not matter here
            repeat (VSMUL_RANDOM) begin
                issue_item(MUL_VSMUL, sew, 1'b1, 1'b1, 1'($urandom % 2),
                           rand_word(), rand_word(), rand_word());
            end
            // min times min saturates, -1 times -1 rounds down to zero
            issue_item(MUL_VSMUL, sew, 1'b1, 1'b1, 1'b0, min_w, min_w, rand_word());
            issue_item(MUL_VSMUL, sew, 1'b1, 1'b1, 1'b0, ones_w, ones_w, rand_word());
        end
        wait_drain();
    endtask

    task automatic test_vmacc();
        sew_e sew;
        test_name = "vmacc";
        for (int wi = 0; wi < 3; wi++) begin
            sew = sew_e'(wi);
            for (int sub = 0; sub < 2; sub++) begin
                repeat (VMACC_PER_CASE) begin
                    issue_item(MUL_VMACC, sew, 1'($urandom % 2), 1'($urandom % 2), sub[0],
                               rand_word(), rand_word(), rand_word());
                end
            end
        end
        wait_drain();
    endtask

    task automatic test_mixed_stream();
        mul_op_e op;
        sew_e    sew;
        test_name = "stream";
        repeat (STREAM_ITEMS) begin
            op  = mul_op_e'(2'($urandom % 4));
            sew = sew_e'(2'($urandom % 3));
            issue_item(op, sew, 1'($urandom % 2), 1'($urandom % 2), 1'($urandom % 2),
                       rand_word(), rand_word(), rand_word());
        end
        wait_drain();
    endtask

    initial begin : main
        void'($urandom(SEED));
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        op_i         = MUL_VMUL;
        sew_i        = SEW_8;
        op1_signed_i = 1'b0;
        op2_signed_i = 1'b0;
        acc_sub_i    = 1'b0;
        op1_i        = '0;
        op2_i        = '0;
        acc_i        = '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        async_rst_ni <= 1'b1;

        test_vmul_after_reset();
        test_vmulh();
        test_vsmul();
        test_vmacc();
        test_mixed_stream();

        repeat (2) @(posedge clk_i);
        $display("errors: %0d value, %0d valid, %0d other, %0d assertion",
                 value_errors, valid_errors, other_errors,
                 simd_mul_top_i.simd_mul_assertions_i.assert_errors);
        if (value_errors + valid_errors + other_errors
            + simd_mul_top_i.simd_mul_assertions_i.assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/simd_mul_block.sv */
////////////////////////////////////////////////////////////////////////////
// 17x17 signed multiply, accumulator slice zero-extended, two cycles deep
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_mul_block (
    input  logic        clk_i,
    input  logic [16:0] op1_i,
    input  logic [16:0] op2_i,
    input  logic [15:0] acc_i,
    input  logic        acc_flag_i,
    input  logic        acc_sub_i,
    output logic [32:0] res_o
);
    logic signed [16:0] op1_q;
    logic signed [16:0] op2_q;
    logic [15:0]        acc_q;
    logic               acc_flag_q;
    logic               acc_sub_q;
    logic signed [32:0] prod;
    logic [32:0]        acc_ext;
    logic [32:0]        sum;

    // operand register
    always_ff @(posedge clk_i) begin
        op1_q      <= op1_i;
        op2_q      <= op2_i;
        acc_q      <= acc_i;
        acc_flag_q <= acc_flag_i;
        acc_sub_q  <= acc_sub_i;
    end

    // 33 bits hold every product of a 16-bit value, signed or not
    always_comb begin
        prod    = 33'(op1_q) * 33'(op2_q);
        acc_ext = {17'b0, acc_q};
        if (!acc_flag_q) begin
            sum = prod;
        end else if (acc_sub_q) begin
            sum = acc_ext - prod;
        end else begin
            sum = acc_ext + prod;
        end
    end

    // product register
    always_ff @(posedge clk_i) begin
        res_o <= sum;
    end

endmodule

`default_nettype wire

/* logic/simd_mul_operand_split.sv */
////////////////////////////////////////////////////////////////////////////
// input register and lane arrangement, one cycle
// unused lane operands and accumulator slices are driven as zero
////////////////////////////////////////////////////////////////////////////
`include "simd_mul_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module simd_mul_operand_split (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         in_valid_i,
    input  simd_mul_pkg::mul_op_e        op_i,
    input  simd_mul_pkg::sew_e           sew_i,
    input  logic                         op1_signed_i,
    input  logic                         op2_signed_i,
    input  logic                         acc_sub_i,
    input  simd_mul_pkg::simd_word_u     op1_i,
    input  simd_mul_pkg::simd_word_u     op2_i,
    input  simd_mul_pkg::simd_word_u     acc_i,
    output logic                         valid_o,
    output simd_mul_pkg::mul_op_e        op_o,
    output simd_mul_pkg::sew_e           sew_o,
    output logic [`SIMD_MUL_LANES*17-1:0] mul_op1_o,
    output logic [`SIMD_MUL_LANES*17-1:0] mul_op2_o,
    output logic [`SIMD_MUL_LANES*16-1:0] mul_acc_o,
    output logic                         acc_flag_o,
    output logic                         acc_sub_o
);
    import simd_mul_pkg::*;

    localparam int unsigned LANES  = `SIMD_MUL_LANES;
    localparam int unsigned GROUPS = `SIMD_MUL_OP_W / 32;

    logic       valid_q;
    mul_op_e    op_q;
    sew_e       sew_q;
    logic       op1_signed_q;
    logic       op2_signed_q;
    logic       acc_sub_q;
    simd_word_u op1_q;
    simd_word_u op2_q;
    simd_word_u acc_q;

    logic [LANES-1:0] op1_signs;
    logic [LANES-1:0] op2_signs;
    simd_word_u       acc_word;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q         <= op_i;
        sew_q        <= sew_i;
        op1_signed_q <= op1_signed_i;
        op2_signed_q <= op2_signed_i;
        acc_sub_q    <= acc_sub_i;
        op1_q        <= op1_i;
        op2_q        <= op2_i;
        acc_q        <= acc_i;
    end

    // spread one word over the lanes; hi_sel picks which lanes of a
    // 32-bit element see the upper halfword
    function automatic logic [LANES*17-1:0] arrange_ops(simd_word_u word,
                                                        logic [LANES-1:0] signs,
                                                        sew_e sew,
                                                        logic [3:0] hi_sel);
        logic [LANES*17-1:0] ops;
        int                  lane;
        ops = '0;
        for (int g = 0; g < GROUPS; g++) begin
            for (int k = 0; k < 4; k++) begin
                lane = 4 * g + k;
                case (sew)
                    SEW_8: ops[17*lane +: 17] = {{9{signs[lane]}}, word.b[lane]};
                    SEW_16: begin
                        // even lanes carry the whole halfword element
                        if (k[0] == 1'b0) begin
                            ops[17*lane +: 17] = {signs[lane+1], word.h[lane/2]};
                        end
                    end
                    SEW_32: begin
                        if (hi_sel[k]) begin
                            ops[17*lane +: 17] = {signs[4*g+3], word.h[2*g+1]};
                        end else begin
                            ops[17*lane +: 17] = {1'b0, word.h[2*g]};
                        end
                    end
                    default: ;
                endcase
            end
        end
        return ops;
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            op1_signs[i] = op1_signed_q & op1_q.b[i][7];
            op2_signs[i] = op2_signed_q & op2_q.b[i][7];
        end
    end

    // lanes 0..3: lo x lo, hi x lo, lo x hi, hi x hi
    assign mul_op1_o = arrange_ops(op1_q, op1_signs, sew_q, 4'b1010);
    assign mul_op2_o = arrange_ops(op2_q, op2_signs, sew_q, 4'b1100);

    ////////////////////////////////////////////////////////////////////////
    // accumulator

    // rounding to nearest-up comes in as half an lsb of the result
    always_comb begin
        acc_word = '0;
        case (op_q)
            MUL_VSMUL: begin
                case (sew_q)
                    SEW_8:   acc_word = {LANES{8'h40}};
                    SEW_16:  acc_word = {(2*GROUPS){16'h4000}};
                    SEW_32:  acc_word = {GROUPS{32'h4000_0000}};
                    default: ;
                endcase
            end
            MUL_VMACC: acc_word = acc_q;
            default: ;
        endcase
    end

    always_comb begin
        mul_acc_o = '0;
        for (int l = 0; l < LANES; l++) begin
            case (sew_q)
                SEW_8:  mul_acc_o[16*l +: 16] = {8'h00, acc_word.b[l]};
                SEW_16: begin
                    if (l % 2 == 0) begin
                        mul_acc_o[16*l +: 16] = acc_word.h[l/2];
                    end
                end
                SEW_32: begin
                    // upper half goes to a lane that is weighted by 2^16
                    if (l % 4 == 0) begin
                        mul_acc_o[16*l +: 16] = acc_word.h[l/2];
                    end else if (l % 4 == 1) begin
                        mul_acc_o[16*l +: 16] = acc_word.h[l/2 + 1];
                    end
                end
                default: ;
            endcase
        end
    end

    assign acc_flag_o = (op_q == MUL_VSMUL) || (op_q == MUL_VMACC);
    assign acc_sub_o  = acc_sub_q && (op_q == MUL_VMACC);
    assign valid_o    = valid_q;
    assign op_o       = op_q;
    assign sew_o      = sew_q;

endmodule

`default_nettype wire

/* logic/simd_mul_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// encodings shared by the multiplier stages and the testbench
////////////////////////////////////////////////////////////////////////////
`include "simd_mul_settings.svh"
`default_nettype none

package simd_mul_pkg;

    // element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    // operation
    typedef enum logic [1:0] {
        // low half of the product
        MUL_VMUL  = 2'd0,
        // high half of the product
        MUL_VMULH = 2'd1,
        // fractional product, rounded to nearest-up and saturated
        MUL_VSMUL = 2'd2,
        // product added to or subtracted from the accumulator
        MUL_VMACC = 2'd3
    } mul_op_e;

    // one SIMD word, read per element width
    typedef union packed {
        logic [`SIMD_MUL_OP_W/8-1:0][7:0]   b;
        logic [`SIMD_MUL_OP_W/16-1:0][15:0] h;
        logic [`SIMD_MUL_OP_W/32-1:0][31:0] w;
    } simd_word_u;

endpackage

`default_nettype wire

/* logic/simd_mul_result_compose.sv */
////////////////////////////////////////////////////////////////////////////
// control delay, 32-bit recombination and result select, one output reg
// saturation applies to MUL_VSMUL only
////////////////////////////////////////////////////////////////////////////
`include "simd_mul_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module simd_mul_result_compose (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         valid_i,
    input  simd_mul_pkg::mul_op_e        op_i,
    input  simd_mul_pkg::sew_e           sew_i,
    input  logic [`SIMD_MUL_LANES*33-1:0] lane_res_i,
    output logic                         result_valid_o,
    output simd_mul_pkg::simd_word_u     result_o
);
    import simd_mul_pkg::*;

    localparam int unsigned LANES  = `SIMD_MUL_LANES;
    localparam int unsigned GROUPS = `SIMD_MUL_OP_W / 32;
    // stages spent in the multiply blocks
    localparam int unsigned CTRL_DLY = `SIMD_MUL_LATENCY - 2;

    logic [CTRL_DLY-1:0]     valid_dly_q;
    mul_op_e                 op_dly_q  [CTRL_DLY];
    sew_e                    sew_dly_q [CTRL_DLY];
    logic [GROUPS-1:0][63:0] prod64;
    simd_word_u              result_d;

    ////////////////////////////////////////////////////////////////////////////
    // control delay line

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_dly_q <= '0;
        end else begin
            valid_dly_q <= {valid_dly_q[CTRL_DLY-2:0], valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        op_dly_q[0]  <= op_i;
        sew_dly_q[0] <= sew_i;
        for (int i = 1; i < CTRL_DLY; i++) begin
            op_dly_q[i]  <= op_dly_q[i-1];
            sew_dly_q[i] <= sew_dly_q[i-1];
        end
    end

    // 32-bit elements, four partial products per group
    always_comb begin
        logic signed [32:0] pp [4];
        for (int g = 0; g < GROUPS; g++) begin
            for (int k = 0; k < 4; k++) begin
                pp[k] = lane_res_i[33*(4*g+k) +: 33];
            end
            prod64[g] = 64'(pp[0]) + (64'(pp[1]) << 16) + (64'(pp[2]) << 16)
                      + (64'(pp[3]) << 32);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result select

    always_comb begin
        logic [32:0] lane;
        result_d = '0;
        for (int i = 0; i < LANES; i++) begin
            lane = lane_res_i[33*i +: 33];
            case (sew_dly_q[CTRL_DLY-1])
                SEW_8: begin
                    case (op_dly_q[CTRL_DLY-1])
                        MUL_VMULH: result_d.b[i] = lane[15:8];
                        MUL_VSMUL: result_d.b[i] = (lane[15] ^ lane[14]) ? 8'h7f : lane[14:7];
                        default:   result_d.b[i] = lane[7:0];
                    endcase
                end
                SEW_16: begin
                    // element i/2 lives in the even lane
                    if (i % 2 == 0) begin
                        case (op_dly_q[CTRL_DLY-1])
                            MUL_VMULH: result_d.h[i/2] = lane[31:16];
                            MUL_VSMUL: begin
                                result_d.h[i/2] = (lane[31] ^ lane[30]) ? 16'h7fff
                                                                        : lane[30:15];
                            end
                            default:   result_d.h[i/2] = lane[15:0];
                        endcase
                    end
                end
                SEW_32: begin
                    if (i % 4 == 0) begin
                        case (op_dly_q[CTRL_DLY-1])
                            MUL_VMULH: result_d.w[i/4] = prod64[i/4][63:32];
                            MUL_VSMUL: begin
                                result_d.w[i/4] = (prod64[i/4][63] ^ prod64[i/4][62])
                                                ? 32'h7fff_ffff : prod64[i/4][62:31];
                            end
                            default:   result_d.w[i/4] = prod64[i/4][31:0];
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    // output register
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= valid_dly_q[CTRL_DLY-1];
        end
    end

    always_ff @(posedge clk_i) begin
        result_o <= result_d;
    end

endmodule

`default_nettype wire

/* logic/simd_mul_settings.svh */
////////////////////////////////////////////////////////////////////////////
// SIMD_MUL_OP_W must be a multiple of 32; one multiply block per byte lane
////////////////////////////////////////////////////////////////////////////
`ifndef SIMD_MUL_SETTINGS_SVH
`define SIMD_MUL_SETTINGS_SVH

`default_nettype none

// width of one SIMD word in bits
`define SIMD_MUL_OP_W 64

// byte lanes, and so the number of 17x17 multiply blocks
`define SIMD_MUL_LANES (`SIMD_MUL_OP_W / 8)

// operand reg, block operand reg, block product reg, output reg
`define SIMD_MUL_LATENCY 4

`default_nettype wire

`endif

/* logic/simd_mul_top.sv */
////////////////////////////////////////////////////////////////////////////
// pipelined SIMD multiplier, fixed 4-cycle latency and no back-pressure
// in_valid_i may be high every cycle, results come back in issue order
////////////////////////////////////////////////////////////////////////////
`include "simd_mul_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module simd_mul_top (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,
    input  logic                    in_valid_i,
    input  simd_mul_pkg::mul_op_e   op_i,
    input  simd_mul_pkg::sew_e      sew_i,
    input  logic                    op1_signed_i,
    input  logic                    op2_signed_i,
    input  logic                    acc_sub_i,
    input  simd_mul_pkg::simd_word_u op1_i,
    input  simd_mul_pkg::simd_word_u op2_i,
    input  simd_mul_pkg::simd_word_u acc_i,
    output logic                    result_valid_o,
    output simd_mul_pkg::simd_word_u result_o
);
    import simd_mul_pkg::*;

    localparam int unsigned LANES = `SIMD_MUL_LANES;

    logic                  split_valid;
    mul_op_e               split_op;
    sew_e                  split_sew;
    logic [LANES*17-1:0]   mul_op1;
    logic [LANES*17-1:0]   mul_op2;
    logic [LANES*16-1:0]   mul_acc;
    logic                  acc_flag;
    logic                  acc_sub;
    logic [LANES*33-1:0]   lane_res;

    simd_mul_operand_split simd_mul_operand_split_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .op_i         (op_i),
        .sew_i        (sew_i),
        .op1_signed_i (op1_signed_i),
        .op2_signed_i (op2_signed_i),
        .acc_sub_i    (acc_sub_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .acc_i        (acc_i),
        .valid_o      (split_valid),
        .op_o         (split_op),
        .sew_o        (split_sew),
        .mul_op1_o    (mul_op1),
        .mul_op2_o    (mul_op2),
        .mul_acc_o    (mul_acc),
        .acc_flag_o   (acc_flag),
        .acc_sub_o    (acc_sub)
    );

    // one multiply-accumulate block per byte lane
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        simd_mul_block simd_mul_block_i (
            .clk_i      (clk_i),
            .op1_i      (mul_op1[17*l +: 17]),
            .op2_i      (mul_op2[17*l +: 17]),
            .acc_i      (mul_acc[16*l +: 16]),
            .acc_flag_i (acc_flag),
            .acc_sub_i  (acc_sub),
            .res_o      (lane_res[33*l +: 33])
        );
    end

    simd_mul_result_compose simd_mul_result_compose_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .valid_i        (split_valid),
        .op_i           (split_op),
        .sew_i          (split_sew),
        .lane_res_i     (lane_res),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/simd_mul_pkg.sv
logic/simd_mul_block.sv
logic/simd_mul_operand_split.sv
logic/simd_mul_result_compose.sv
logic/simd_mul_top.sv
dv/simd_mul_assertions.sv
dv/simd_mul_tb.sv
